// File: rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction word as seen on the instruction memory output
`define INSTR_WIDTH 16

// register file has sixteen 8-bit registers
`define REG_SEL_WIDTH 4

// stack pointer lives in the r14/r15 pair
`define SP_LOW_REG 14

// number of sequencer steps
`define STEP_COUNT 5

`endif

// File: rtl/isaPkg.sv
`include "cpu_settings.svh"

package isaPkg;

    typedef enum logic [4:0] {
        aluImm,     // R-I, includes LDI
        ioIn,
        ioOut,
        aluReg,     // R-R and R
        pairMem,    // R-RP load/store
        pairOp,     // RP inc, dec, indirect jump
        jmp,
        call,
        ret,
        halt,
        nop
    } instrClass_t;

    // condition field, bits 15:13
    typedef enum logic [2:0] {
        condAlways    = 3'd0,
        condCarrySet  = 3'd1,
        condCarryClr  = 3'd2,
        condZeroSet   = 3'd3,
        condZeroClr   = 3'd4,
        condNegSet    = 3'd5,
        condNegClr    = 3'd6,
        condAlwaysAlt = 3'd7
    } cond_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flags_t;

    typedef struct packed {
        instrClass_t                opClass;
        logic                       condMet;
        logic [`REG_SEL_WIDTH-1:0] dest;    // bits 15:12
        logic [`REG_SEL_WIDTH-1:0] src;     // bits 11:8
        logic [2:0]                 pair;    // bits 11:9
        logic [4:0]                 subOp;   // bits 7:3
        logic [2:0]                 immOp;   // bits 3:1
    } decodedInstr_t;

endpackage

// File: rtl/ctlPkg.sv
`include "cpu_settings.svh"

package ctlPkg;

    typedef enum logic [$clog2(`STEP_COUNT)-1:0] {
        stepExec,       // first cycle of every instruction
        stepIoWait,     // data comes back from memory/IO
        stepJmpTarget,  // target word on iMemOut
        stepCallHigh,   // second push of a call
        stepRetHigh     // last ret cycle
    } step_t;

    typedef enum logic [1:0] {
        regSrcAlu = 2'b00,
        regSrcMem = 2'b10
    } regSrc_t;

    typedef enum logic [1:0] {
        bSrcReg    = 2'b00,
        bSrcNibble = 2'b01,  // {4'd0, iMemOut[11:8]}
        bSrcByte   = 2'b10   // iMemOut[11:4]
    } aluBSrc_t;

    typedef enum logic [1:0] {
        dataPcHigh = 2'b00,
        dataPcLow  = 2'b01,
        dataAlu    = 2'b10
    } memDataSrc_t;

    typedef enum logic [1:0] {
        addrPair        = 2'b00,
        addrPort        = 2'b01,  // 8-bit port number from the word
        addrPairPlusOne = 2'b10
    } memAddrSrc_t;

    typedef enum logic [2:0] {
        fetchPcPlusOne = 3'b000,  // skips the word after this one
        fetchPc        = 3'b001,
        fetchInstrWord = 3'b011,
        fetchPair      = 3'b100,
        fetchReturn    = 3'b101   // return register and memory data
    } fetchAddrSrc_t;

    typedef struct packed {
        regSrc_t                    src;
        logic [`REG_SEL_WIDTH-1:0] outBSelect;
        logic                       writeEnable;
        logic                       incPair;
        logic                       decPair;
    } regFileCtl_t;

    typedef struct packed {
        aluBSrc_t   srcBSelect;
        logic [3:0] mode;
        logic       flagEnable;
    } aluCtl_t;

    typedef struct packed {
        memDataSrc_t dataSelect;
        memAddrSrc_t addrSelect;
        logic        writeEn;
        logic        readEn;
    } memCtl_t;

    typedef struct packed {
        fetchAddrSrc_t addrSelect;
        logic          readEnable;
        logic          pcWriteEn;
    } fetchCtl_t;

endpackage

// File: rtl/instrDecoder.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module instrDecoder (
    input  logic [`INSTR_WIDTH-1:0] iMemOut,
    input  isaPkg::flags_t          flags,
    output isaPkg::decodedInstr_t   decoded
);

    logic [4:0]          subOp;
    logic [2:0]          lowBits;
    isaPkg::cond_t       cond;
    isaPkg::instrClass_t opClass;
    logic                condMet;

    assign subOp   = iMemOut[7:3];
    assign lowBits = iMemOut[2:0];
    assign cond    = isaPkg::cond_t'(iMemOut[15:13]);

    // first match wins
    always_comb begin
        if (iMemOut[0] && iMemOut[3:1] != 3'b111) begin
            opClass = isaPkg::aluImm;
        end else if (lowBits == 3'b010) begin
            opClass = isaPkg::ioIn;
        end else if (lowBits == 3'b100) begin
            opClass = isaPkg::ioOut;
        end else if (lowBits != 3'b000) begin
            opClass = isaPkg::nop;
        end else if (subOp >= 5'd1 && subOp <= 5'd12) begin
            opClass = isaPkg::aluReg;
        end else if (subOp >= 5'd13 && subOp <= 5'd18) begin
            opClass = isaPkg::pairMem;
        end else if (subOp >= 5'd19 && subOp <= 5'd21) begin
            opClass = isaPkg::pairOp;
        end else if (subOp == 5'd22) begin
            opClass = isaPkg::jmp;
        end else if (subOp == 5'd23) begin
            opClass = isaPkg::call;
        end else if (subOp == 5'd24) begin
            opClass = isaPkg::ret;
        end else if (subOp == 5'd29) begin
            opClass = isaPkg::halt;
        end else begin
            opClass = isaPkg::nop;  // 0, 25..28 and 30, 31
        end
    end

    always_comb begin
        case (cond)
            isaPkg::condCarrySet: condMet = flags.carry;
            isaPkg::condCarryClr: condMet = ~flags.carry;
            isaPkg::condZeroSet:  condMet = flags.zero;
            isaPkg::condZeroClr:  condMet = ~flags.zero;
            isaPkg::condNegSet:   condMet = flags.negative;
            isaPkg::condNegClr:   condMet = ~flags.negative;
            default:              condMet = 1'b1;  // both always codes
        endcase
    end

    assign decoded.opClass = opClass;
    assign decoded.condMet = condMet;
    assign decoded.dest    = iMemOut[15:12];
    assign decoded.src     = iMemOut[11:8];
    assign decoded.pair    = iMemOut[11:9];
    assign decoded.subOp   = subOp;
    assign decoded.immOp   = iMemOut[3:1];

endmodule

// File: rtl/stepSequencer.sv
`timescale 1ns/1ns

module stepSequencer (
    input  logic                  clk,
    input  logic                  rstN,
    input  isaPkg::decodedInstr_t decoded,
    output ctlPkg::step_t         step
);

    ctlPkg::step_t nextStep;
    logic          isPairLoad;

    // loads are the upper half of the R-RP range
    assign isPairLoad = (decoded.opClass == isaPkg::pairMem) && decoded.subOp[4];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step <= ctlPkg::stepExec;
        end else begin
            step <= nextStep;
        end
    end

    always_comb begin
        nextStep = ctlPkg::stepExec;  // single-cycle unless noted
        case (step)
            ctlPkg::stepExec: begin
                if (decoded.opClass == isaPkg::ioIn || isPairLoad) begin
                    nextStep = ctlPkg::stepIoWait;
                end else if (decoded.condMet) begin
                    case (decoded.opClass)
                        isaPkg::jmp:  nextStep = ctlPkg::stepJmpTarget;
                        isaPkg::call: nextStep = ctlPkg::stepCallHigh;
                        isaPkg::ret:  nextStep = ctlPkg::stepIoWait;
                        default:      nextStep = ctlPkg::stepExec;
                    endcase
                end
            end
            ctlPkg::stepIoWait: begin
                // ret pops a second byte
                if (decoded.opClass == isaPkg::ret) begin
                    nextStep = ctlPkg::stepRetHigh;
                end
            end
            default: nextStep = ctlPkg::stepExec;
        endcase
    end

endmodule

// File: rtl/controlWordDecode.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module controlWordDecode (
    input  isaPkg::decodedInstr_t decoded,
    input  ctlPkg::step_t         step,
    output ctlPkg::regFileCtl_t   regFileCtl,
    output ctlPkg::aluCtl_t       aluCtl,
    output ctlPkg::memCtl_t       memCtl,
    output ctlPkg::fetchCtl_t     fetchCtl
);

    localparam logic [3:0] aluPassB = 4'b0000;
    localparam logic [3:0] aluPassA = 4'b1101;
    localparam logic [`REG_SEL_WIDTH-1:0] spLowReg = `SP_LOW_REG;

    logic [`REG_SEL_WIDTH-1:0] pairLowReg;
    logic                      pairInc;
    logic                      pairDec;

    assign pairLowReg = {decoded.pair, 1'b0};  // even register of the pair

    // R-RP: 13/16 plain, 14/17 increment, 15/18 decrement
    assign pairInc = (decoded.subOp == 5'd14) || (decoded.subOp == 5'd17);
    assign pairDec = (decoded.subOp == 5'd15) || (decoded.subOp == 5'd18);

    always_comb begin
        regFileCtl.src         = ctlPkg::regSrcAlu;
        regFileCtl.outBSelect  = decoded.dest;
        regFileCtl.writeEnable = 1'b0;
        regFileCtl.incPair     = 1'b0;
        regFileCtl.decPair     = 1'b0;
        aluCtl.srcBSelect      = ctlPkg::bSrcReg;
        aluCtl.mode            = aluPassB;
        aluCtl.flagEnable      = 1'b0;
        memCtl.dataSelect      = ctlPkg::dataAlu;
        memCtl.addrSelect      = ctlPkg::addrPair;
        memCtl.writeEn         = 1'b0;
        memCtl.readEn          = 1'b0;
        fetchCtl.addrSelect    = ctlPkg::fetchPc;
        fetchCtl.readEnable    = 1'b1;
        fetchCtl.pcWriteEn     = 1'b1;

        case (step)
            ctlPkg::stepExec: begin
                case (decoded.opClass)
                    isaPkg::aluImm: begin
                        regFileCtl.writeEnable = 1'b1;
                        aluCtl.srcBSelect      = ctlPkg::bSrcByte;
                        aluCtl.mode            = {1'b0, decoded.immOp};
                        aluCtl.flagEnable      = (decoded.immOp != 3'b000);  // not on LDI
                    end
                    isaPkg::ioIn: begin
                        regFileCtl.src      = ctlPkg::regSrcMem;
                        memCtl.addrSelect   = ctlPkg::addrPort;
                        memCtl.readEn       = 1'b1;
                        fetchCtl.readEnable = 1'b0;
                        fetchCtl.pcWriteEn  = 1'b0;
                    end
                    isaPkg::ioOut: begin
                        memCtl.addrSelect = ctlPkg::addrPort;
                        memCtl.writeEn    = 1'b1;  // dest register via ALU pass B
                    end
                    isaPkg::aluReg: begin
                        regFileCtl.outBSelect  = decoded.src;
                        regFileCtl.writeEnable = 1'b1;
                        aluCtl.mode            = decoded.subOp[3:0];
                        aluCtl.flagEnable      = 1'b1;
                    end
                    isaPkg::pairMem: begin
                        regFileCtl.outBSelect = pairLowReg;
                        aluCtl.mode           = aluPassA;
                        if (decoded.subOp[4]) begin
                            regFileCtl.src      = ctlPkg::regSrcMem;
                            memCtl.readEn       = 1'b1;
                            fetchCtl.readEnable = 1'b0;
                            fetchCtl.pcWriteEn  = 1'b0;
                        end else begin
                            memCtl.writeEn     = 1'b1;
                            regFileCtl.incPair = pairInc;
                            regFileCtl.decPair = pairDec;
                        end
                    end
                    isaPkg::pairOp: begin
                        regFileCtl.outBSelect = pairLowReg;
                        regFileCtl.incPair    = (decoded.subOp == 5'd19);
                        regFileCtl.decPair    = (decoded.subOp == 5'd20);
                        if (decoded.subOp == 5'd21 && decoded.condMet) begin
                            fetchCtl.addrSelect = ctlPkg::fetchPair;
                        end
                    end
                    isaPkg::jmp: begin
                        if (decoded.condMet) begin
                            fetchCtl.pcWriteEn = 1'b0;  // target word comes next
                        end else begin
                            fetchCtl.addrSelect = ctlPkg::fetchPcPlusOne;
                        end
                    end
                    isaPkg::call: begin
                        regFileCtl.outBSelect = spLowReg;
                        memCtl.dataSelect     = ctlPkg::dataPcLow;
                        if (decoded.condMet) begin
                            regFileCtl.decPair = 1'b1;
                            memCtl.writeEn     = 1'b1;  // push low byte first
                            fetchCtl.pcWriteEn = 1'b0;
                        end else begin
                            fetchCtl.addrSelect = ctlPkg::fetchPcPlusOne;
                        end
                    end
                    isaPkg::ret: begin
                        regFileCtl.outBSelect = spLowReg;
                        memCtl.addrSelect     = ctlPkg::addrPairPlusOne;
                        memCtl.readEn         = 1'b1;
                        if (decoded.condMet) begin
                            regFileCtl.incPair  = 1'b1;
                            fetchCtl.addrSelect = ctlPkg::fetchReturn;
                            fetchCtl.readEnable = 1'b0;
                            fetchCtl.pcWriteEn  = 1'b0;
                        end
                    end
                    isaPkg::halt: begin
                        fetchCtl.readEnable = 1'b0;
                        fetchCtl.pcWriteEn  = 1'b0;
                    end
                    default: ;  // nop keeps the defaults
                endcase
            end
            ctlPkg::stepIoWait: begin
                case (decoded.opClass)
                    isaPkg::ioIn: begin
                        regFileCtl.src         = ctlPkg::regSrcMem;
                        regFileCtl.writeEnable = 1'b1;
                        memCtl.addrSelect      = ctlPkg::addrPort;
                        memCtl.readEn          = 1'b1;
                    end
                    isaPkg::pairMem: begin
                        regFileCtl.src         = ctlPkg::regSrcMem;
                        regFileCtl.outBSelect  = pairLowReg;
                        regFileCtl.writeEnable = 1'b1;
                        // pair moves once the data is taken
                        regFileCtl.incPair     = pairInc;
                        regFileCtl.decPair     = pairDec;
                        aluCtl.mode            = aluPassA;
                        memCtl.readEn          = 1'b1;
                    end
                    isaPkg::ret: begin
                        regFileCtl.outBSelect = spLowReg;
                        regFileCtl.incPair    = 1'b1;
                        memCtl.addrSelect     = ctlPkg::addrPairPlusOne;
                        memCtl.readEn         = 1'b1;
                        fetchCtl.addrSelect   = ctlPkg::fetchReturn;
                        fetchCtl.readEnable   = 1'b0;
                        fetchCtl.pcWriteEn    = 1'b0;
                    end
                    default: ;
                endcase
            end
            ctlPkg::stepJmpTarget: begin
                fetchCtl.addrSelect = ctlPkg::fetchInstrWord;
            end
            ctlPkg::stepCallHigh: begin
                regFileCtl.outBSelect = spLowReg;
                regFileCtl.decPair    = 1'b1;
                memCtl.dataSelect     = ctlPkg::dataPcHigh;
                memCtl.writeEn        = 1'b1;
                fetchCtl.addrSelect   = ctlPkg::fetchInstrWord;
            end
            ctlPkg::stepRetHigh: begin
                regFileCtl.outBSelect = spLowReg;
                memCtl.addrSelect     = ctlPkg::addrPairPlusOne;
                memCtl.readEn         = 1'b1;
                fetchCtl.addrSelect   = ctlPkg::fetchReturn;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/cpuControl.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuControl (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`INSTR_WIDTH-1:0] iMemOut,
    input  isaPkg::flags_t          flags,
    output ctlPkg::regFileCtl_t     regFileCtl,
    output ctlPkg::aluCtl_t         aluCtl,
    output ctlPkg::memCtl_t         memCtl,
    output ctlPkg::fetchCtl_t       fetchCtl
);

    isaPkg::decodedInstr_t decoded;
    ctlPkg::step_t         step;

    instrDecoder u_instrDecoder (
        .iMemOut (iMemOut),
        .flags   (flags),
        .decoded (decoded)
    );

    stepSequencer u_stepSequencer (
        .clk     (clk),
        .rstN    (rstN),
        .decoded (decoded),
        .step    (step)
    );

    controlWordDecode u_controlWordDecode (
        .decoded    (decoded),
        .step       (step),
        .regFileCtl (regFileCtl),
        .aluCtl     (aluCtl),
        .memCtl     (memCtl),
        .fetchCtl   (fetchCtl)
    );

endmodule

// File: bench/cpuControl_properties.sv
`timescale 1ns/1ns

module cpuControl_properties (
    input logic                  clk,
    input logic                  rstN,
    input isaPkg::decodedInstr_t decoded,
    input ctlPkg::regFileCtl_t   regFileCtl,
    input ctlPkg::memCtl_t       memCtl,
    input ctlPkg::fetchCtl_t     fetchCtl
);

    logic isHalt;

    assign isHalt = (decoded.opClass == isaPkg::halt);

    memStrobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memCtl.writeEn && memCtl.readEn))
        else $error("memory read and write strobes active together");

    pairStrobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(regFileCtl.incPair && regFileCtl.decPair))
        else $error("pair increment and decrement active together");

    // longest instruction is a taken RET
    pcAdvances: assert property (@(posedge clk) disable iff (!rstN)
        (!fetchCtl.pcWriteEn && !isHalt) |-> ##[1:2] fetchCtl.pcWriteEn)
        else $error("PC not written within 3 cycles");

endmodule

bind cpuControl cpuControl_properties checkProps (
    .clk        (clk),
    .rstN       (rstN),
    .decoded    (decoded),
    .regFileCtl (regFileCtl),
    .memCtl     (memCtl),
    .fetchCtl   (fetchCtl)
);

// File: bench/cpuControl_tb.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuControl_tb;

    localparam int numRowsMax    = 32;
    localparam int timeoutCycles = 8;

    typedef struct packed {
        logic writeEnable;
        logic memWrite;
        logic memRead;
        logic flagEnable;
    } firstCycle_t;

    typedef struct packed {
        logic wrLast;  // writeEnable in the completing cycle
        logic push;    // memory write and decPair in every cycle
        logic pop;     // incPair in every cycle but the last
    } laterCycles_t;

    typedef struct packed {
        logic [`INSTR_WIDTH-1:0] instr;
        isaPkg::flags_t          flg;
        logic [3:0]              lat;
        firstCycle_t             first;
        logic                    modeChk;
        logic [3:0]              mode;
        laterCycles_t            later;
    } testRow_t;

    logic                    clk;
    logic                    rstN;
    logic [`INSTR_WIDTH-1:0] iMemOut;
    isaPkg::flags_t          flags;
    ctlPkg::regFileCtl_t     regFileCtl;
    ctlPkg::aluCtl_t         aluCtl;
    ctlPkg::memCtl_t         memCtl;
    ctlPkg::fetchCtl_t       fetchCtl;

    testRow_t stimTable [numRowsMax];
    string    rowName [numRowsMax];
    int       rowCount;
    int       errCount;
    int       passCount;
    int       failCount;

    cpuControl i_cpuControl (
        .clk        (clk),
        .rstN       (rstN),
        .iMemOut    (iMemOut),
        .flags      (flags),
        .regFileCtl (regFileCtl),
        .aluCtl     (aluCtl),
        .memCtl     (memCtl),
        .fetchCtl   (fetchCtl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errCount == errorsBefore) begin
            passCount++;
            $display("test %s: pass", name);
        end else begin
            failCount++;
            $display("test %s: fail", name);
        end
    endtask

    // bits under mask get random register and immediate fields
    task automatic addRow(input string name, input logic [15:0] base, input logic [15:0] mask,
                          input logic [2:0] flg, input logic [3:0] lat, input logic [3:0] first,
                          input logic modeChk, input logic [3:0] mode, input logic [2:0] later);
        logic [31:0] r;
        r = $urandom();
        stimTable[rowCount].instr   = base | (r[15:0] & mask);
        stimTable[rowCount].flg     = flg;
        stimTable[rowCount].lat     = lat;
        stimTable[rowCount].first   = first;
        stimTable[rowCount].modeChk = modeChk;
        stimTable[rowCount].mode    = mode;
        stimTable[rowCount].later   = later;
        rowName[rowCount]           = name;
        rowCount++;
    endtask

    task automatic buildTable();
        // first = {wr, memWr, memRd, flagEn}, later = {wrLast, push, pop}
        addRow("LDI",            16'h0001, 16'hfff0, 3'b000, 1, 4'b1000, 1, 4'd0, 3'b100);
        addRow("ALUI op3",       16'h0007, 16'hfff0, 3'b000, 1, 4'b1001, 1, 4'd3, 3'b100);
        addRow("ALUI op6",       16'h000d, 16'hfff0, 3'b000, 1, 4'b1001, 1, 4'd6, 3'b100);
        addRow("ALU reg op1",    16'h0008, 16'hff00, 3'b000, 1, 4'b1001, 1, 4'd1, 3'b100);
        addRow("ALU reg op5",    16'h0028, 16'hff00, 3'b000, 1, 4'b1001, 1, 4'd5, 3'b100);
        addRow("ALU reg op12",   16'h0060, 16'hff00, 3'b000, 1, 4'b1001, 1, 4'd12, 3'b100);
        addRow("IN",             16'h0002, 16'hff00, 3'b000, 2, 4'b0010, 0, 4'd0, 3'b100);
        addRow("OUT",            16'h0004, 16'hff00, 3'b000, 1, 4'b0100, 0, 4'd0, 3'b000);
        addRow("pair load",      16'h0080, 16'hff00, 3'b000, 2, 4'b0010, 0, 4'd0, 3'b100);
        addRow("pair load inc",  16'h0088, 16'hff00, 3'b000, 2, 4'b0010, 0, 4'd0, 3'b100);
        addRow("pair store",     16'h0068, 16'hff00, 3'b000, 1, 4'b0100, 0, 4'd0, 3'b000);
        addRow("pair store dec", 16'h0078, 16'hff00, 3'b000, 1, 4'b0100, 0, 4'd0, 3'b000);
        addRow("pair inc",       16'h0098, 16'hff00, 3'b000, 1, 4'b0000, 0, 4'd0, 3'b000);
        addRow("pair jump",      16'h00a8, 16'hff00, 3'b000, 1, 4'b0000, 0, 4'd0, 3'b000);
        addRow("JMP C taken",    16'h20b0, 16'h0000, 3'b100, 2, 4'b0000, 0, 4'd0, 3'b000);
        addRow("JMP C skipped",  16'h20b0, 16'h0000, 3'b000, 1, 4'b0000, 0, 4'd0, 3'b000);
        addRow("JMP NZ skipped", 16'h80b0, 16'h0000, 3'b010, 1, 4'b0000, 0, 4'd0, 3'b000);
        addRow("CALL taken",     16'h00b8, 16'h0000, 3'b000, 2, 4'b0100, 0, 4'd0, 3'b010);
        addRow("CALL N skipped", 16'ha0b8, 16'h0000, 3'b000, 1, 4'b0000, 0, 4'd0, 3'b000);
        addRow("RET taken",      16'h00c0, 16'h0000, 3'b000, 3, 4'b0010, 0, 4'd0, 3'b001);
        addRow("RET NN taken",   16'hc0c0, 16'h0000, 3'b000, 3, 4'b0010, 0, 4'd0, 3'b001);
        addRow("RET NC skipped", 16'h40c0, 16'h0000, 3'b100, 1, 4'b0010, 0, 4'd0, 3'b000);
        addRow("NOP op25",       16'h00c8, 16'hff00, 3'b000, 1, 4'b0000, 0, 4'd0, 3'b000);
        addRow("NOP zero",       16'h0000, 16'h0000, 3'b000, 1, 4'b0000, 0, 4'd0, 3'b000);
        addRow("ALUI op7 is NOP", 16'h000f, 16'hff00, 3'b000, 1, 4'b0000, 0, 4'd0, 3'b000);
    endtask

    task automatic runRow(input int idx);
        testRow_t row;
        int       cycle;
        logic     done;
        int       errorsBefore;
        row          = stimTable[idx];
        errorsBefore = errCount;
        cycle        = 0;
        done         = 1'b0;
        @(posedge clk);
        #5;
        iMemOut = row.instr;
        flags   = row.flg;
        while (!done && cycle < timeoutCycles) begin
            cycle++;
            @(negedge clk);  // outputs settled mid-cycle
            if (cycle == 1) begin
                checkValue("regFileCtl.writeEnable", 32'(row.first.writeEnable),
                           32'(regFileCtl.writeEnable));
                checkValue("memCtl.writeEn", 32'(row.first.memWrite), 32'(memCtl.writeEn));
                checkValue("memCtl.readEn", 32'(row.first.memRead), 32'(memCtl.readEn));
                checkValue("aluCtl.flagEnable", 32'(row.first.flagEnable),
                           32'(aluCtl.flagEnable));
                if (row.modeChk) begin
                    checkValue("aluCtl.mode", 32'(row.mode), 32'(aluCtl.mode));
                end
            end
            if (row.later.push) begin
                checkValue("memCtl.writeEn", 32'd1, 32'(memCtl.writeEn));
                checkValue("regFileCtl.decPair", 32'd1, 32'(regFileCtl.decPair));
            end
            if (row.later.pop && cycle < int'(row.lat)) begin
                checkValue("regFileCtl.incPair", 32'd1, 32'(regFileCtl.incPair));
            end
            if (fetchCtl.pcWriteEn) begin
                done = 1'b1;
                if (cycle > 1) begin
                    checkValue("regFileCtl.writeEnable", 32'(row.later.wrLast),
                               32'(regFileCtl.writeEnable));
                end
            end
        end
        if (!done) begin
            $display("timeout: pcWriteEn did not rise within %0d cycles", timeoutCycles);
            errCount++;
        end else begin
            checkValue("latency", 32'(row.lat), 32'(cycle));
        end
        reportTest(rowName[idx], errorsBefore);
    endtask

    task automatic testHalt();
        int errorsBefore;
        errorsBefore = errCount;
        @(posedge clk);
        #5;
        iMemOut = 16'h00e8;  // sub-opcode 29
        flags   = 3'b000;
        repeat (4) begin
            @(negedge clk);
            checkValue("fetchCtl.pcWriteEn", 32'd0, 32'(fetchCtl.pcWriteEn));
            checkValue("fetchCtl.readEnable", 32'd0, 32'(fetchCtl.readEnable));
        end
        @(posedge clk);
        #5;
        iMemOut = 16'h0000;
        @(negedge clk);
        checkValue("fetchCtl.pcWriteEn", 32'd1, 32'(fetchCtl.pcWriteEn));
        reportTest("HLT holds the PC", errorsBefore);
    endtask

    task automatic testResetMidInstr();
        int errorsBefore;
        errorsBefore = errCount;
        @(posedge clk);
        #5;
        iMemOut = 16'h00c0;  // unconditional RET
        flags   = 3'b000;
        @(negedge clk);
        checkValue("fetchCtl.pcWriteEn", 32'd0, 32'(fetchCtl.pcWriteEn));
        @(posedge clk);
        #5;
        rstN = 1'b0;  // second RET cycle, RET stays on iMemOut
        @(negedge clk);
        checkValue("regFileCtl.incPair", 32'd1, 32'(regFileCtl.incPair));
        @(negedge clk);
        // held in the first RET step instead of the last one
        checkValue("fetchCtl.pcWriteEn", 32'd0, 32'(fetchCtl.pcWriteEn));
        @(posedge clk);
        #5;
        iMemOut = 16'h0000;
        @(negedge clk);
        checkValue("regFileCtl.writeEnable", 32'd0, 32'(regFileCtl.writeEnable));
        checkValue("memCtl.writeEn", 32'd0, 32'(memCtl.writeEn));
        checkValue("regFileCtl.incPair", 32'd0, 32'(regFileCtl.incPair));
        checkValue("regFileCtl.decPair", 32'd0, 32'(regFileCtl.decPair));
        checkValue("fetchCtl.pcWriteEn", 32'd1, 32'(fetchCtl.pcWriteEn));
        @(posedge clk);
        #5;
        rstN = 1'b1;
        @(negedge clk);
        checkValue("fetchCtl.pcWriteEn", 32'd1, 32'(fetchCtl.pcWriteEn));
        reportTest("reset during RET", errorsBefore);
    endtask

    initial begin
        void'($urandom(32'ha8da));
        rstN      = 1'b0;
        iMemOut   = 16'h0000;
        flags     = 3'b000;
        rowCount  = 0;
        errCount  = 0;
        passCount = 0;
        failCount = 0;
        buildTable();
        repeat (2) @(posedge clk);
        #5;
        rstN = 1'b1;
        for (int i = 0; i < rowCount; i++) begin
            runRow(i);
        end
        testHalt();
        testResetMidInstr();
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: cpuControl.f
+incdir+rtl
rtl/isaPkg.sv
rtl/ctlPkg.sv
rtl/instrDecoder.sv
rtl/stepSequencer.sv
rtl/controlWordDecode.sv
rtl/cpuControl.sv
bench/cpuControl_properties.sv
bench/cpuControl_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= cpuControl_tb
FILELIST  ?= cpuControl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
